// ==== hw/pov_cmd_pkg.sv ====
package pov_cmd_pkg;

    ////////////////////////////////////////////////////////////
    // widths
    localparam int BYTE_W      = 8;
    localparam int FRAME_BYTES = 7;
    localparam int FRAME_W     = BYTE_W * FRAME_BYTES;
    localparam int CONF_W      = 48;
    localparam int ROT_W       = 16;
    localparam int REPLY_W     = 48;
    localparam int REJ_W       = 8;

    typedef logic [BYTE_W-1:0]  byte_t;
    typedef logic [FRAME_W-1:0] frame_t;
    typedef logic [2:0]         len_t;
    typedef logic [CONF_W-1:0]  conf_t;
    typedef logic [ROT_W-1:0]   rot_t;
    typedef logic [REPLY_W-1:0] reply_t;
    typedef logic [REJ_W-1:0]   rej_cnt_t;

    ////////////////////////////////////////////////////////////
    // opcodes and their total frame length in bytes
    localparam byte_t OP_WR_CONF   = 8'h01;
    localparam byte_t OP_WR_ROT    = 8'h02;
    localparam byte_t OP_RGB_EN    = 8'h03;
    localparam byte_t OP_RD_STATUS = 8'h80;
    localparam byte_t OP_RD_CONF   = 8'h81;
    localparam byte_t OP_RD_ROT    = 8'h82;

    localparam len_t LEN_WR_CONF = 3'd7;
    localparam len_t LEN_WR_ROT  = 3'd3;
    localparam len_t LEN_RGB_EN  = 3'd2;
    localparam len_t LEN_RD      = 3'd1;

    // decoded operation, one cycle wide
    typedef enum logic [2:0] {
        NONE, SET_CONF, SET_ROT, SET_RGB, SEL_CONF, SEL_ROT, SEL_STATUS, REJECT
    } op_t;

    typedef enum logic {IDLE, SHIFT} rx_state_t;

endpackage

// ==== hw/spi_edge_if.sv ====
// SPI events, already in the clk domain
interface spi_edge_if;

    // synchronized SS fell / rose
    logic frame_start;
    logic frame_end;

    // SPI clock edges, only while SS is low
    logic sclk_rise;
    logic sclk_fall;

    modport rx (
        output frame_start, frame_end, sclk_rise, sclk_fall
    );

    modport tx (
        input frame_start, frame_end, sclk_rise, sclk_fall
    );

endinterface

// ==== hw/spi_frame_rx.sv ====
module spi_frame_rx #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 spi_clk,
    input  logic                 spi_ss,
    input  logic                 spi_mosi,
    spi_edge_if.rx               edges,
    output logic                 frame_valid,
    output pov_cmd_pkg::frame_t  frame,
    output pov_cmd_pkg::len_t    frame_len
);
    import pov_cmd_pkg::*;

    logic [SYNC_STAGES-1:0] sclk_sync;
    logic [SYNC_STAGES-1:0] ss_sync;
    logic [SYNC_STAGES-1:0] mosi_sync;
    logic                   sclk_s, ss_s, mosi_s;
    logic                   sclk_q, ss_q;

    rx_state_t              state;
    logic [2:0]             bit_cnt;
    len_t                   byte_cnt;
    logic [BYTE_W-2:0]      byte_sr;
    byte_t                  next_byte;
    logic                   take_bit;
    logic                   byte_done;

    ////////////////////////////////////////////////////////////
    // pin synchronizers, SS idles high
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            sclk_sync <= '0;
            ss_sync   <= '1;
            mosi_sync <= '0;
            sclk_q    <= 1'b0;
            ss_q      <= 1'b1;
        end else begin
            sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], spi_clk};
            ss_sync   <= {ss_sync[SYNC_STAGES-2:0], spi_ss};
            mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], spi_mosi};
            sclk_q    <= sclk_s;
            ss_q      <= ss_s;
        end
    end

    assign sclk_s = sclk_sync[SYNC_STAGES-1];
    assign ss_s   = ss_sync[SYNC_STAGES-1];
    assign mosi_s = mosi_sync[SYNC_STAGES-1];

    assign edges.frame_start = ss_q & ~ss_s;
    assign edges.frame_end   = ~ss_q & ss_s;
    assign edges.sclk_rise   = ~ss_s & sclk_s & ~sclk_q;
    assign edges.sclk_fall   = ~ss_s & ~sclk_s & sclk_q;

    ////////////////////////////////////////////////////////////
    // bit and byte assembly, data ignored once the frame is full
    assign take_bit  = (state == SHIFT) && edges.sclk_rise && (byte_cnt != len_t'(FRAME_BYTES));
    assign byte_done = take_bit && (bit_cnt == 3'd7);
    assign next_byte = {byte_sr, mosi_s};

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state       <= IDLE;
            bit_cnt     <= '0;
            byte_cnt    <= '0;
            frame_valid <= 1'b0;
            frame_len   <= '0;
        end else begin
            frame_valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (edges.frame_start) begin
                        state    <= SHIFT;
                        bit_cnt  <= '0;
                        byte_cnt <= '0;
                    end
                end
                SHIFT: begin
                    if (edges.frame_end) begin
                        // trailing partial byte is simply not counted
                        state       <= IDLE;
                        frame_valid <= 1'b1;
                        frame_len   <= byte_cnt;
                    end else if (take_bit) begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (byte_done) begin
                            byte_cnt <= byte_cnt + 3'd1;
                        end
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // first byte lands in the top bits
    always_ff @(posedge clk) begin
        if (state == IDLE && edges.frame_start) begin
            frame <= '0;
        end else if (take_bit) begin
            byte_sr <= next_byte[BYTE_W-2:0];
            if (byte_done) begin
                frame[(FRAME_BYTES-1-byte_cnt)*BYTE_W +: BYTE_W] <= next_byte;
            end
        end
    end

    a_valid_single : assert property (
        @(posedge clk) disable iff (!nrst) frame_valid |=> !frame_valid
    );

endmodule

// ==== hw/cmd_decoder.sv ====
module cmd_decoder (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 frame_valid,
    input  pov_cmd_pkg::frame_t  frame,
    input  pov_cmd_pkg::len_t    frame_len,
    output pov_cmd_pkg::op_t     op,
    output pov_cmd_pkg::frame_t  op_data
);
    import pov_cmd_pkg::*;

    byte_t opcode;
    op_t   next_op;

    assign opcode = frame[FRAME_W-1 -: BYTE_W];

    ////////////////////////////////////////////////////////////
    // opcode table, length must match exactly
    always_comb begin
        next_op = REJECT;
        case (opcode)
            OP_WR_CONF: begin
                if (frame_len == LEN_WR_CONF) next_op = SET_CONF;
            end
            OP_WR_ROT: begin
                if (frame_len == LEN_WR_ROT) next_op = SET_ROT;
            end
            OP_RGB_EN: begin
                if (frame_len == LEN_RGB_EN) next_op = SET_RGB;
            end
            OP_RD_CONF: begin
                if (frame_len == LEN_RD) next_op = SEL_CONF;
            end
            OP_RD_ROT: begin
                if (frame_len == LEN_RD) next_op = SEL_ROT;
            end
            OP_RD_STATUS: begin
                if (frame_len == LEN_RD) next_op = SEL_STATUS;
            end
            default: next_op = REJECT;
        endcase
        // SS toggled without a whole byte
        if (frame_len == '0) begin
            next_op = NONE;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op <= NONE;
        end else begin
            op <= frame_valid ? next_op : NONE;
        end
    end

    // drop the opcode byte, first operand moves to the top
    always_ff @(posedge clk) begin
        if (frame_valid) begin
            op_data <= frame << BYTE_W;
        end
    end

endmodule

// ==== hw/cmd_executor.sv ====
module cmd_executor (
    input  logic                 clk,
    input  logic                 nrst,
    input  pov_cmd_pkg::op_t     op,
    input  pov_cmd_pkg::frame_t  op_data,
    output pov_cmd_pkg::conf_t   configuration,
    output pov_cmd_pkg::rot_t    rotation,
    output logic                 rgb_enable,
    output logic                 new_config,
    output pov_cmd_pkg::reply_t  reply
);
    import pov_cmd_pkg::*;

    rej_cnt_t reject_count;
    op_t      reply_sel;

    ////////////////////////////////////////////////////////////
    // display registers
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            configuration <= '0;
            rotation      <= '0;
            rgb_enable    <= 1'b0;
            new_config    <= 1'b0;
            reject_count  <= '0;
            reply_sel     <= SEL_STATUS;
        end else begin
            new_config <= 1'b0;
            case (op)
                SET_CONF: begin
                    configuration <= op_data[FRAME_W-1 -: CONF_W];
                    new_config    <= 1'b1;
                end
                SET_ROT: rotation <= op_data[FRAME_W-1 -: ROT_W];
                // only bit 0 of the data byte counts
                SET_RGB: rgb_enable <= op_data[FRAME_W-BYTE_W];
                SEL_CONF, SEL_ROT, SEL_STATUS: reply_sel <= op;
                REJECT: begin
                    if (reject_count != '1) begin
                        reject_count <= reject_count + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

    // reply source, held until the next read command
    always_comb begin
        case (reply_sel)
            SEL_CONF: reply = configuration;
            SEL_ROT:  reply = {rotation, {(REPLY_W-ROT_W){1'b0}}};
            default:  reply = {reject_count, rgb_enable, {(REPLY_W-REJ_W-1){1'b0}}};
        endcase
    end

    a_new_config_src : assert property (
        @(posedge clk) disable iff (!nrst) new_config |-> $past(op == SET_CONF)
    );

endmodule

// ==== hw/reply_shifter.sv ====
module reply_shifter (
    input  logic                 clk,
    input  logic                 nrst,
    input  pov_cmd_pkg::reply_t  reply,
    spi_edge_if.tx               edges,
    output logic                 spi_miso
);
    import pov_cmd_pkg::*;

    reply_t shift_reg;
    logic   active;

    ////////////////////////////////////////////////////////////
    // frame window as seen through the synchronizers
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            active <= 1'b0;
        end else if (edges.frame_start) begin
            active <= 1'b1;
        end else if (edges.frame_end) begin
            active <= 1'b0;
        end
    end

    // msb first, host samples on the next rising edge
    always_ff @(posedge clk) begin
        if (edges.frame_start) begin
            shift_reg <= reply;
        end else if (active && edges.sclk_fall) begin
            shift_reg <= {shift_reg[REPLY_W-2:0], 1'b0};
        end
    end

    assign spi_miso = active & shift_reg[REPLY_W-1];

    a_shift_in_frame : assert property (
        @(posedge clk) disable iff (!nrst) edges.sclk_fall |-> active
    );

endmodule

// ==== hw/pov_cmd_top.sv ====
module pov_cmd_top #(
    parameter int SYNC_STAGES = 2
) (
    input  logic                 clk,
    input  logic                 nrst,
    input  logic                 spi_clk,
    input  logic                 spi_ss,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    output pov_cmd_pkg::conf_t   configuration,
    output pov_cmd_pkg::rot_t    rotation,
    output logic                 rgb_enable,
    output logic                 new_config
);
    import pov_cmd_pkg::*;

    logic   frame_valid;
    frame_t frame;
    len_t   frame_len;
    op_t    op;
    frame_t op_data;
    reply_t reply;

    spi_edge_if edges ();

    ////////////////////////////////////////////////////////////
    // receive, decode, execute, reply
    spi_frame_rx #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_rx (
        .clk         (clk),
        .nrst        (nrst),
        .spi_clk     (spi_clk),
        .spi_ss      (spi_ss),
        .spi_mosi    (spi_mosi),
        .edges       (edges.rx),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_len   (frame_len)
    );

    cmd_decoder u_dec (
        .clk         (clk),
        .nrst        (nrst),
        .frame_valid (frame_valid),
        .frame       (frame),
        .frame_len   (frame_len),
        .op          (op),
        .op_data     (op_data)
    );

    cmd_executor u_exec (
        .clk           (clk),
        .nrst          (nrst),
        .op            (op),
        .op_data       (op_data),
        .configuration (configuration),
        .rotation      (rotation),
        .rgb_enable    (rgb_enable),
        .new_config    (new_config),
        .reply         (reply)
    );

    reply_shifter u_reply (
        .clk      (clk),
        .nrst     (nrst),
        .reply    (reply),
        .edges    (edges.tx),
        .spi_miso (spi_miso)
    );

endmodule

// ==== test/tb_pov_cmd.sv ====
module tb_pov_cmd;
    import pov_cmd_pkg::*;

    localparam int N_RANDOM      = 300;
    localparam int N_SATURATE    = 260;
    localparam int N_FRAMES      = N_RANDOM + N_SATURATE + 24;
    // 7 bytes at 8 clk per bit, plus lead, trail and idle
    localparam int MAX_FRAME_CYC = 7 * 8 * 8 + 20;

    logic   clk;
    logic   nrst;
    logic   spi_clk;
    logic   spi_ss;
    logic   spi_mosi;
    logic   spi_miso;
    conf_t  configuration;
    rot_t   rotation;
    logic   rgb_enable;
    logic   new_config;

    integer seed = 32'hfcd7;
    int     pulse_cnt = 0;

    // model state, selection 0 status, 1 conf, 2 rot
    conf_t    m_conf = '0;
    rot_t     m_rot = '0;
    logic     m_rgb = 1'b0;
    rej_cnt_t m_rej = '0;
    int       m_sel = 0;

    byte_t op_tab[6] = '{OP_WR_CONF, OP_WR_ROT, OP_RGB_EN, OP_RD_STATUS, OP_RD_CONF, OP_RD_ROT};
    int    len_tab[6] = '{7, 3, 2, 1, 1, 1};

    pov_cmd_top #(
        .SYNC_STAGES (2)
    ) u_dut (
        .clk           (clk),
        .nrst          (nrst),
        .spi_clk       (spi_clk),
        .spi_ss        (spi_ss),
        .spi_mosi      (spi_mosi),
        .spi_miso      (spi_miso),
        .configuration (configuration),
        .rotation      (rotation),
        .rgb_enable    (rgb_enable),
        .new_config    (new_config)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    // one count per high cycle of new_config
    always @(negedge clk) begin
        if (new_config === 1'b1) begin
            pulse_cnt = pulse_cnt + 1;
        end
    end

    initial begin
        #(N_FRAMES * MAX_FRAME_CYC * 10 * 2);
        $display("timeout: the frame sequence did not finish in time");
        $display("Regression failed");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // compare tasks
    task automatic check_conf(input string name, input conf_t got, input conf_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_rot(input string name, input rot_t got, input rot_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_reply(input string name, input reply_t got, input reply_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // register model
    function automatic reply_t model_reply();
        case (m_sel)
            1:       return m_conf;
            2:       return {m_rot, 32'h0};
            default: return {m_rej, m_rgb, 39'h0};
        endcase
    endfunction

    task automatic model_apply(input frame_t f, input int n, output int exp_pulse);
        byte_t opc;
        opc = f[55:48];
        exp_pulse = 0;
        if (n == 0) begin
            return;
        end
        if (opc == 8'h01 && n == 7) begin
            m_conf = f[47:0];
            exp_pulse = 1;
        end else if (opc == 8'h02 && n == 3) begin
            m_rot = f[47:32];
        end else if (opc == 8'h03 && n == 2) begin
            m_rgb = f[40];
        end else if (opc == 8'h80 && n == 1) begin
            m_sel = 0;
        end else if (opc == 8'h81 && n == 1) begin
            m_sel = 1;
        end else if (opc == 8'h82 && n == 1) begin
            m_sel = 2;
        end else if (m_rej != 8'hff) begin
            m_rej = m_rej + 8'd1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // mode 0 bit-bang, half period of 4 clk, miso taken at rising sclk
    task automatic spi_xfer(input int n_bytes, input frame_t tx, output frame_t rx);
        int i;
        rx = '0;
        @(negedge clk);
        spi_ss = 1'b0;
        for (i = 0; i < n_bytes * 8; i++) begin
            spi_mosi = tx[55-i];
            repeat (4) @(negedge clk);
            spi_clk = 1'b1;
            rx[55-i] = spi_miso;
            repeat (4) @(negedge clk);
            spi_clk = 1'b0;
        end
        repeat (4) @(negedge clk);
        spi_ss = 1'b1;
        spi_mosi = 1'b0;
        repeat (10) @(negedge clk);
    endtask

    task automatic run_frame(input byte_t opc, input int n);
        frame_t tx;
        frame_t rx;
        reply_t exp_reply;
        reply_t mask;
        int     exp_pulse;
        int     pulses_before;
        int     i;
        tx = '0;
        tx[55:48] = opc;
        for (i = 1; i < n; i++) begin
            tx[55-8*i -: 8] = byte_t'($random(seed));
        end
        exp_reply = model_reply();
        pulses_before = pulse_cnt;
        spi_xfer(n, tx, rx);
        model_apply(tx, n, exp_pulse);
        // only the bits that were clocked out
        if (n >= 6) begin
            mask = '1;
        end else begin
            mask = ~({48{1'b1}} >> (n * 8));
        end
        check_reply("spi_miso reply", rx[55:8], exp_reply & mask);
        check_bit("spi_miso after reply", |rx[7:0], 1'b0);
        check_count("new_config pulses", pulse_cnt - pulses_before, exp_pulse);
        check_conf("configuration", configuration, m_conf);
        check_rot("rotation", rotation, m_rot);
        check_bit("rgb_enable", rgb_enable, m_rgb);
        check_bit("spi_miso idle", spi_miso, 1'b0);
    endtask

    task automatic random_frame();
        int    kind;
        int    idx;
        byte_t opc;
        int    n;
        kind = $unsigned($random(seed)) % 10;
        idx = $unsigned($random(seed)) % 6;
        if (kind < 6) begin
            opc = op_tab[idx];
            n = len_tab[idx];
        end else if (kind < 8) begin
            opc = op_tab[idx];
            n = 1 + $unsigned($random(seed)) % 7;
        end else begin
            opc = byte_t'($random(seed));
            n = 1 + $unsigned($random(seed)) % 7;
        end
        run_frame(opc, n);
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence
    initial begin
        nrst = 1'b0;
        spi_clk = 1'b0;
        spi_ss = 1'b1;
        spi_mosi = 1'b0;
        repeat (4) @(negedge clk);
        nrst = 1'b1;
        repeat (8) begin
            @(negedge clk);
            check_bit("spi_miso idle", spi_miso, 1'b0);
        end
        check_conf("configuration", configuration, '0);
        check_rot("rotation", rotation, '0);
        check_bit("rgb_enable", rgb_enable, 1'b0);
        check_count("new_config pulses", pulse_cnt, 0);

        // writes, then each read followed by a frame long enough for 48 bits
        run_frame(OP_WR_CONF, 7);
        run_frame(OP_RD_CONF, 1);
        run_frame(8'hff, 6);
        run_frame(OP_WR_ROT, 3);
        run_frame(OP_RGB_EN, 2);
        run_frame(OP_RD_ROT, 1);
        run_frame(8'h44, 7);
        run_frame(OP_RD_STATUS, 1);
        run_frame(8'hff, 6);

        // wrong lengths and unknown opcodes
        run_frame(OP_WR_CONF, 5);
        run_frame(OP_WR_ROT, 2);
        run_frame(OP_RGB_EN, 3);
        run_frame(OP_RD_CONF, 2);
        run_frame(8'h55, 4);
        run_frame(OP_RD_STATUS, 1);
        run_frame(8'hff, 6);

        repeat (N_RANDOM) random_frame();

        // reject counter saturates
        repeat (N_SATURATE) run_frame(8'h7f, 1);
        run_frame(OP_RD_STATUS, 1);
        run_frame(8'hff, 6);

        $display("Regression passed");
        $finish;
    end

endmodule

// ==== pov_cmd_top.f ====
hw/pov_cmd_pkg.sv
hw/spi_edge_if.sv
hw/spi_frame_rx.sv
hw/cmd_decoder.sv
hw/cmd_executor.sv
hw/reply_shifter.sv
hw/pov_cmd_top.sv
test/tb_pov_cmd.sv

// ==== Bender.yml ====
package:
  name: pov_cmd

sources:
  - hw/pov_cmd_pkg.sv
  - hw/spi_edge_if.sv
  - hw/spi_frame_rx.sv
  - hw/cmd_decoder.sv
  - hw/cmd_executor.sv
  - hw/reply_shifter.sv
  - hw/pov_cmd_top.sv
  - target: test
    files:
      - test/tb_pov_cmd.sv
